// ==== sim/ternary_mvm_vectors.txt ====
// Ternary MVM vectors, read with $readmemh as one list of 12-bit hex words
// Order: command, 24 weight words, frame count, then per frame twelve inputs
// x0..x11 followed by twelve expected results y0..y11 modulo 2^N
// Command F = 7, frames of 8 slices
070
// Weight words, two per output row, rows 0..5 then 6..11
555 555 FFF FFF 000 000 001 000 000 C00 555 FFF
DDD DDD AAA AAA 014 000 003 003 000 400 FFF 555
// Frame count
004
// Frame 0 inputs 1..12
001 002 003 004 005 006 007 008 009 00A 00B 00C
04E 0B2 000 001 0F4 0DC 0FA 000 005 0F8 00C 024
// Frame 1 all ones inputs
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0F4 00C 000 0FF 001 000 000 000 0FE 002 0FF 000
// Frame 2 zero inputs
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
// Frame 3 mixed inputs
080 000 07F 010 000 000 001 0FF 000 000 000 040
04F 0B1 000 080 0C0 0CF 0B1 000 07F 07F 040 031

// ==== flist.f ====
hw/ternary_mvm_pkg.sv
hw/mvm_sequencer.sv
hw/weight_loader.sv
hw/ternary_partial_sum.sv
hw/serial_accumulator.sv
hw/ternary_mvm_top.sv
sim/tb_clock_gen.sv
sim/mvm_sequencer_asserts.sv
sim/ternary_mvm_tb.sv

// ==== Makefile ====
# Verilator build and run for the ternary matrix-vector multiplier

BIN  := obj_dir/Vternary_mvm_tb
SRCS := $(filter-out +%,$(shell cat flist.f))

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module ternary_mvm_tb \
		-Mdir obj_dir -o Vternary_mvm_tb

run: $(BIN) sim/ternary_mvm_vectors.txt
	./$(BIN) | tee sim.log
	@grep -qx "ALL TESTS PASSED" sim.log || (echo "Simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== sim/ternary_mvm_tb.sv ====
// Testbench for the ternary matrix-vector multiplier. Loads a command,
// weights and frames from the vector file, adds LCG frames checked by a
// reference model, and covers reset in idle and in the middle of multiply.
// Run from the project root so the vector file path resolves.

`timescale 1ns/1ps

module ternary_mvm_tb;

  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 20;
  localparam int MAX_FRAMES   = 16;
  localparam int RAND_FRAMES  = 6;
  localparam int WAIT_LIMIT   = 50;
  localparam int VEC_DEPTH    = 128;

  logic       clk;
  logic       rst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [11:0] vec_mem [VEC_DEPTH];
  logic [11:0] wt_words [24];          // Current weight load, word k at index k
  int          x_val [MAX_FRAMES][12];
  int          exp_val [MAX_FRAMES][12];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  logic        aborted;

  tb_clock_gen u_clk (.clk(clk));

  ternary_mvm_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference result y_j of frame f, reduced modulo 2^n_bits
  function automatic int model_result(input int f, input int j, input int n_bits);
    logic [1:0] code;
    int         acc;
    int         idx;
    acc = 0;
    for (int i = 0; i < 12; i++) begin
      idx  = 12 * j + i;
      code = wt_words[idx / 6][2 * (idx % 6) +: 2];
      if (code == 2'b01) begin
        acc = acc + x_val[f][i];
      end else if (code == 2'b11) begin
        acc = acc - x_val[f][i];
      end
    end
    return acc & ((1 << n_bits) - 1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // Drive one word 1 ns after the edge, then move to the next drive point
  task automatic drive_cycle(input logic [11:0] word);
    ui_in  = word[11:4];
    uio_in = {word[3:0], 4'h0};
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle_pins();
    check_value("uo_out", 32'(uo_out), 32'h0);
    check_value("uio_out", 32'(uio_out), 32'h0);
    check_value("uio_oe", 32'(uio_oe), 32'h0F);
  endtask

  task automatic wait_for_multiply();
    int waited;
    waited = 0;
    while (!u_dut.u_sequencer.mult_en && waited < WAIT_LIMIT) begin
      drive_cycle(12'h000);
      waited++;
    end
    if (!u_dut.u_sequencer.mult_en) begin
      $display("Timeout: multiply phase not entered within %0d cycles of the weight load",
               WAIT_LIMIT);
      errors++;
      aborted = 1'b1;
    end else begin
      checks++;
      assert (waited == 0) else begin
        errors++;
        $display("Multiply phase started %0d cycles after the last weight word", waited);
      end
    end
  endtask

  task automatic load_matrix(input logic [11:0] cmd);
    drive_cycle(cmd);
    for (int k = 0; k < 24; k++) begin
      drive_cycle(wt_words[k]);
    end
    wait_for_multiply();
  endtask

  task automatic make_random_frames(input int first, input int count, input int n_bits);
    logic [31:0] r;
    for (int f = first; f < first + count; f++) begin
      for (int i = 0; i < 12; i++) begin
        r           = lcg_next();
        x_val[f][i] = int'(r[23:16]) & ((1 << n_bits) - 1);
      end
      for (int j = 0; j < 12; j++) begin
        exp_val[f][j] = model_result(f, j, n_bits);
      end
    end
  endtask

  // Stream frames back to back, LSB slice first, and check every lane
  task automatic run_frames(input int num_frames, input int n_bits);
    logic [11:0] slice_q [$];
    logic [11:0] out_q [$];
    logic [11:0] slice;
    int          y;
    for (int f = 0; f < num_frames; f++) begin
      for (int b = 0; b < n_bits; b++) begin
        for (int i = 0; i < 12; i++) begin
          slice[i] = x_val[f][i][b];
        end
        slice_q.push_back(slice);
      end
    end
    for (int s = 0; s <= slice_q.size(); s++) begin
      if (s < slice_q.size()) begin
        drive_cycle(slice_q[s]);
      end else begin
        drive_cycle(12'h000);
      end
      if (s > 0) begin
        out_q.push_back({uo_out, uio_out[3:0]});  // Result bits of slice s-1
      end
    end
    for (int f = 0; f < num_frames; f++) begin
      for (int j = 0; j < 12; j++) begin
        y = 0;
        for (int b = 0; b < n_bits; b++) begin
          if (out_q[f * n_bits + b][j]) begin
            y = y | (1 << b);
          end
        end
        check_value($sformatf("y%0d of frame %0d", j, f), 32'(y), 32'(exp_val[f][j]));
      end
    end
  endtask

  initial begin
    int          n_bits;
    int          file_frames;
    logic [31:0] r;
    rst_n     = 1'b0;
    ena       = 1'b1;
    ui_in     = 8'h00;
    uio_in    = 8'h00;
    errors    = 0;
    checks    = 0;
    aborted   = 1'b0;
    lcg_state = 32'h9a6a;
    $readmemh("sim/ternary_mvm_vectors.txt", vec_mem);

    @(posedge clk);
    #1;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      check_idle_pins();
      if (c < RESET_CYCLES - 1) begin
        drive_cycle(12'h000);
      end
    end
    rst_n = 1'b1;
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      drive_cycle(12'h000);
      check_idle_pins();
    end

    // File command, weights and frames, then LCG frames straight after
    n_bits      = int'(vec_mem[0][11:4]) + 1;
    file_frames = int'(vec_mem[25]);
    for (int k = 0; k < 24; k++) begin
      wt_words[k] = vec_mem[1 + k];
    end
    for (int f = 0; f < file_frames; f++) begin
      for (int i = 0; i < 12; i++) begin
        x_val[f][i]   = int'(vec_mem[26 + 24 * f + i]);
        exp_val[f][i] = int'(vec_mem[38 + 24 * f + i]);
      end
    end
    load_matrix(vec_mem[0]);
    if (!aborted) begin
      make_random_frames(file_frames, RAND_FRAMES, n_bits);
      run_frames(file_frames + RAND_FRAMES, n_bits);

      for (int c = 0; c < 3; c++) begin      // Part of a frame, then reset
        r = lcg_next();
        drive_cycle(r[27:16]);
      end
      rst_n = 1'b0;
      for (int c = 0; c < RESET_CYCLES; c++) begin
        drive_cycle(12'h000);
        check_idle_pins();
      end
      rst_n = 1'b1;
      for (int c = 0; c < 5; c++) begin
        drive_cycle(12'h000);
        check_idle_pins();
      end
      for (int k = 0; k < 24; k++) begin
        r           = lcg_next();
        wt_words[k] = r[27:16];
      end
      load_matrix(12'h030);                  // F = 3, four bit frames
    end
    if (!aborted) begin
      make_random_frames(0, RAND_FRAMES, 4);
      run_frames(RAND_FRAMES, 4);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/mvm_sequencer_asserts.sv ====
// Concurrent checks on the sequencer phases, bound into every
// mvm_sequencer instance. Covers phase exclusion, load length,
// the frame start at the top of multiply and the idle exit path.

`timescale 1ns/1ps

module mvm_sequencer_asserts (
  input logic clk,
  input logic rst_n,
  input logic load_en,
  input logic mult_en,
  input logic lsb
);
  import ternary_mvm_pkg::*;

  logic [5:0] load_run;   // Cycles load_en has been high so far

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_run <= '0;
    end else if (load_en) begin
      load_run <= load_run + 6'd1;
    end else begin
      load_run <= '0;
    end
  end

  a_one_phase: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_en && mult_en))
    else $error("load_en and mult_en are high together");

  a_load_short: assert property (@(posedge clk) disable iff (!rst_n)
    load_en |-> (load_run < 6'(LOAD_WORDS)))
    else $error("load_en stays high longer than the weight load");

  a_load_len: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(load_en) |-> (load_run == 6'(LOAD_WORDS) && mult_en))
    else $error("load phase did not last exactly one full weight load");

  // First multiply slice opens a frame
  a_lsb_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mult_en) |-> lsb)
    else $error("multiply phase did not start with lsb on its first slice");

  // Idle may only move on to load
  a_idle_exit: assert property (@(posedge clk) disable iff (!rst_n)
    (!load_en && !mult_en) |=> !mult_en)
    else $error("sequencer left idle without passing through load");

endmodule

bind mvm_sequencer mvm_sequencer_asserts u_seq_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .load_en (load_en),
  .mult_en (mult_en),
  .lsb     (lsb)
);

// ==== sim/tb_clock_gen.sv ====
// Free-running testbench clock with a 10 ns period.
// Instantiate once in the testbench top and use its clk output.

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  localparam time HALF_PERIOD = 5ns;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

// ==== hw/ternary_mvm_top.sv ====
// Top level of the ternary matrix-vector multiplier on Tiny Tapeout pins.
// The 12-bit input word is ui_in over uio_in[7:4]; the 12 result bits
// leave on uo_out over uio_out[3:0], two cycles after their slice.

`timescale 1ns/1ps

module ternary_mvm_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ena,       // Always high when powered, not used
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);
  import ternary_mvm_pkg::*;

  ui_word_u                    ui_word;
  logic                        load_en;
  logic                        mult_en;
  logic                        lsb;
  logic [WEIGHT_BITS-1:0]      weights;
  logic [NUM_OUT*PSUM_W-1:0]   psum;
  logic                        psum_lsb;
  logic                        psum_valid;
  logic [NUM_OUT-1:0]          out_bits;

  assign ui_word = {ui_in, uio_in[7:4]};  // Lower uio nibble is output only

  mvm_sequencer u_sequencer (
    .clk     (clk),
    .rst_n   (rst_n),
    .ui_word (ui_word),
    .load_en (load_en),
    .mult_en (mult_en),
    .lsb     (lsb)
  );

  weight_loader u_loader (
    .clk     (clk),
    .load_en (load_en),
    .ui_word (ui_word),
    .weights (weights)
  );

  ternary_partial_sum u_partial_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .ui_word    (ui_word),
    .weights    (weights),
    .mult_en    (mult_en),
    .lsb        (lsb),
    .psum       (psum),
    .psum_lsb   (psum_lsb),
    .psum_valid (psum_valid)
  );

  serial_accumulator u_accumulator (
    .clk        (clk),
    .rst_n      (rst_n),
    .psum       (psum),
    .psum_lsb   (psum_lsb),
    .psum_valid (psum_valid),
    .out_bits   (out_bits)
  );

  assign {uo_out, uio_out[3:0]} = out_bits;
  assign uio_out[7:4] = 4'h0;
  assign uio_oe       = 8'h0F;            // uio[3:0] drive, uio[7:4] listen

endmodule

// ==== hw/serial_accumulator.sv ====
// Second pipeline stage, a bit-serial accumulator per output lane.
// Each partial sum is weighted by 2^b through the carry: the lane adds the
// sum to its carry, emits bit 0 and keeps the rest, shifted, as new carry.
// psum_lsb restarts a frame with a zero carry.

`timescale 1ns/1ps

module serial_accumulator (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [ternary_mvm_pkg::NUM_OUT*ternary_mvm_pkg::PSUM_W-1:0] psum,
  input  logic                                              psum_lsb,
  input  logic                                              psum_valid,
  output logic [ternary_mvm_pkg::NUM_OUT-1:0]               out_bits
);
  import ternary_mvm_pkg::*;

  logic signed [CARRY_W-1:0] carry     [NUM_OUT];
  logic signed [CARRY_W-1:0] carry_in  [NUM_OUT];
  logic signed [PSUM_W-1:0]  lane_psum [NUM_OUT];
  logic signed [CARRY_W:0]   acc_sum   [NUM_OUT];

  always_comb begin
    for (int j = 0; j < NUM_OUT; j++) begin
      lane_psum[j] = psum[PSUM_W*j +: PSUM_W];
      carry_in[j]  = psum_lsb ? '0 : carry[j];   // New frame starts clean
      acc_sum[j]   = lane_psum[j] + carry_in[j]; // Both sign extended
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < NUM_OUT; j++) begin
      if (!rst_n || !psum_valid) begin
        out_bits[j] <= 1'b0;
        carry[j]    <= '0;
      end else begin
        out_bits[j] <= acc_sum[j][0];
        carry[j]    <= acc_sum[j][CARRY_W:1];    // Arithmetic shift right
      end
    end
  end

endmodule

// ==== hw/ternary_partial_sum.sv ====
// First pipeline stage. For one input bit slice, forms per output lane the
// signed sum of the ternary weights whose input bit is set, and registers
// all twelve sums together with the frame-start and valid flags.
// Weight of input i for output j sits at bits 2(12j+i)+1..2(12j+i).

`timescale 1ns/1ps

module ternary_partial_sum (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  ternary_mvm_pkg::ui_word_u                         ui_word,
  input  logic [ternary_mvm_pkg::WEIGHT_BITS-1:0]           weights,
  input  logic                                              mult_en,
  input  logic                                              lsb,
  output logic [ternary_mvm_pkg::NUM_OUT*ternary_mvm_pkg::PSUM_W-1:0] psum,
  output logic                                              psum_lsb,
  output logic                                              psum_valid
);
  import ternary_mvm_pkg::*;

  logic signed [PSUM_W-1:0] lane_sum [NUM_OUT];

  // Contribution of one weight when its input bit is set
  function automatic logic signed [PSUM_W-1:0] ternary_term(
    input logic [WEIGHT_W-1:0] w,
    input logic                x
  );
    logic signed [PSUM_W-1:0] term;
    term = '0;
    if (x && (w == W_POS)) begin
      term = PSUM_W'(1);
    end else if (x && (w == W_NEG)) begin
      term = -PSUM_W'(1);
    end
    return term;
  endfunction

  always_comb begin
    for (int j = 0; j < NUM_OUT; j++) begin
      lane_sum[j] = '0;
      for (int i = 0; i < NUM_IN; i++) begin
        lane_sum[j] = lane_sum[j] +
                      ternary_term(weights[WEIGHT_W*(NUM_IN*j+i) +: WEIGHT_W],
                                   ui_word.slice[i]);
      end
    end
  end

  // Sums are payload, only meaningful with psum_valid
  always_ff @(posedge clk) begin
    for (int j = 0; j < NUM_OUT; j++) begin
      psum[PSUM_W*j +: PSUM_W] <= lane_sum[j];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psum_lsb   <= 1'b0;
      psum_valid <= 1'b0;
    end else begin
      psum_lsb   <= lsb;       // Travels with its slice
      psum_valid <= mult_en;
    end
  end

endmodule

// ==== hw/weight_loader.sv ====
// Weight store for the whole ternary matrix. During the load phase each
// input word is shifted in at the top, so after all load words the first
// word sits in the lowest bits. The matrix holds while load_en is low.

`timescale 1ns/1ps

module weight_loader (
  input  logic                                   clk,
  input  logic                                   load_en,
  input  ternary_mvm_pkg::ui_word_u              ui_word,
  output logic [ternary_mvm_pkg::WEIGHT_BITS-1:0] weights
);
  import ternary_mvm_pkg::*;

  // Word k lands at bits 12k+11..12k after the full load
  always_ff @(posedge clk) begin
    if (load_en) begin
      weights <= {ui_word.wts, weights[WEIGHT_BITS-1:WORD_W]};
    end
  end

endmodule

// ==== hw/mvm_sequencer.sv ====
// Phase control for the multiplier. Waits in idle for a nonzero command
// word, raises load_en for the weight words, then runs the multiply phase
// forever, marking the first slice of each frame with lsb.

`timescale 1ns/1ps

module mvm_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ternary_mvm_pkg::ui_word_u ui_word,
  output logic                      load_en,
  output logic                      mult_en,
  output logic                      lsb
);
  import ternary_mvm_pkg::*;

  logic [7:0] count;        // Load word index, then bit index in frame
  logic [7:0] frame_last;   // F of the command, last bit index of a frame
  logic       cmd_seen;

  // Idle is load_en and mult_en both low
  assign cmd_seen = !load_en && !mult_en && (ui_word.slice != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_en    <= 1'b0;
      mult_en    <= 1'b0;
      count      <= '0;
      frame_last <= '0;
    end else if (load_en) begin
      if (count == 8'(LOAD_WORDS - 1)) begin  // Last weight word
        load_en <= 1'b0;
        mult_en <= 1'b1;
        count   <= '0;
      end else begin
        count <= count + 8'd1;
      end
    end else if (mult_en) begin
      if (count == frame_last) begin         // Wrap at frame end
        count <= '0;
      end else begin
        count <= count + 8'd1;
      end
    end else if (cmd_seen) begin
      load_en    <= 1'b1;
      frame_last <= ui_word.cmd.frame_m1;
      count      <= '0;
    end
  end

  // First slice of every frame
  assign lsb = mult_en && (count == '0);

endmodule

// ==== hw/ternary_mvm_pkg.sv ====
// Shared sizes, the ternary weight encoding and the input word views
// of the ternary matrix-vector multiplier. Modules import it in their body
// and use scoped names in their port lists.

package ternary_mvm_pkg;

  localparam int NUM_IN      = 12;                            // Input lanes
  localparam int NUM_OUT     = 12;                            // Output lanes
  localparam int WORD_W      = 12;                            // Input word per cycle
  localparam int WEIGHT_W    = 2;                             // Bits per ternary weight
  localparam int WEIGHT_BITS = NUM_IN * NUM_OUT * WEIGHT_W;   // 288
  localparam int LOAD_WORDS  = WEIGHT_BITS / WORD_W;          // 24
  localparam int PSUM_W      = 5;                             // Holds -12..+12
  localparam int CARRY_W     = 6;                             // Serial carry per lane

  // Ternary codes, 00 and 10 both read as zero
  localparam logic [WEIGHT_W-1:0] W_POS = 2'b01;
  localparam logic [WEIGHT_W-1:0] W_NEG = 2'b11;

  // One input word, decoded according to the current phase
  typedef union packed {
    struct packed {
      logic [7:0] frame_m1;                                   // Frame length minus one
      logic [3:0] rsvd;                                       // Ignored
    } cmd;
    logic [5:0][WEIGHT_W-1:0] wts;                            // Six weights, index 0 lowest
    logic [NUM_IN-1:0]        slice;                          // Bit i belongs to input i
  } ui_word_u;

endpackage
